//--- bp_assertions.sv
`timescale 1ns/1ps

module bp_assertions (
    input logic       clk,
    input logic       rstn,
    input logic       fetch_valid,
    input logic       pred_valid,
    input logic [1:0] pred_taken
);

    // one prediction per fetch, exactly one cycle later
    a_pred_follows_fetch: assert property (
        @(posedge clk) disable iff (!rstn) fetch_valid |=> pred_valid
    ) else $error("pred_valid missing one cycle after fetch_valid");

    a_no_extra_pred: assert property (
        @(posedge clk) disable iff (!rstn) !fetch_valid |=> !pred_valid
    ) else $error("pred_valid high without a fetch in the cycle before");

    // encoding 2'b11 is reserved
    a_kind_legal: assert property (
        @(posedge clk) disable iff (!rstn) pred_taken != 2'b11
    ) else $error("pred_taken carries the reserved encoding");

    a_quiet_in_reset: assert property (
        @(posedge clk) !rstn |-> !pred_valid
    ) else $error("pred_valid high while in reset");

endmodule

bind bp_top bp_assertions u_assertions (
    .clk         (clk),
    .rstn        (rstn),
    .fetch_valid (fetch_valid),
    .pred_valid  (pred_valid),
    .pred_taken  (pred_taken)
);

//--- bp_fetch_stage.sv
`timescale 1ns/1ps

module bp_fetch_stage
    import bp_isa_pkg::*;
#(
    parameter int INDEX_WIDTH = 6
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   fetch_valid,
    input  addr_t                  fetch_pc,
    bp_lookup_if.fetch             lk,
    output logic [INDEX_WIDTH-1:0] rd_index
);

    addr_t   fallthrough_next;
    pc_tag_t tag_next;

    // direct mapped, index sits just above the 8-byte granule
    assign rd_index = fetch_pc[INDEX_WIDTH+2:3];
    assign tag_next = fetch_pc[31:3];

    // upper word of a granule only has 4 bytes left
    always_comb begin
        if (fetch_pc[2]) begin
            fallthrough_next = fetch_pc + 32'd4;
        end else begin
            fallthrough_next = fetch_pc + 32'd8;
        end
    end

    // strobe is one cycle wide
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lk.valid <= 1'b0;
        end else begin
            lk.valid <= fetch_valid;
        end
    end

    // held in step with the registered table reads
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lk.pc_tag      <= '0;
            lk.fallthrough <= '0;
        end else if (fetch_valid) begin
            lk.pc_tag      <= tag_next;
            lk.fallthrough <= fallthrough_next;
        end
    end

endmodule

//--- bp_if.sv
`timescale 1ns/1ps

// registered lookup result, fetch side to select side
interface bp_lookup_if
    import bp_isa_pkg::*, bp_pred_pkg::*;
    ();

    logic       valid;
    pc_tag_t    pc_tag;
    addr_t      fallthrough;
    btb_entry_t entry;
    ctr_t       ctr;

    modport fetch (
        output valid,
        output pc_tag,
        output fallthrough
    );

    // registered read ports of the two tables
    modport tbl (
        output entry,
        output ctr
    );

    modport select (
        input valid,
        input pc_tag,
        input fallthrough,
        input entry,
        input ctr
    );

endinterface

// one write port plus a combinational read port into a table
interface bp_table_wr_if #(
    parameter type data_t      = logic,
    parameter int  INDEX_WIDTH = 6
) ();

    logic                   we;
    logic [INDEX_WIDTH-1:0] waddr;
    data_t                  wdata;
    logic [INDEX_WIDTH-1:0] raddr;
    data_t                  rdata;

    modport writer (
        output we,
        output waddr,
        output wdata,
        output raddr,
        input  rdata
    );

    modport tbl (
        input  we,
        input  waddr,
        input  wdata,
        input  raddr,
        output rdata
    );

endinterface

//--- bp_isa_pkg.sv
package bp_isa_pkg;

    // fetch and branch addresses
    typedef logic [31:0] addr_t;

    // fetch granule is 8 bytes, so the tag is pc[31:3]
    localparam int TAG_WIDTH = 29;

    typedef logic [TAG_WIDTH-1:0] pc_tag_t;

    // branch type as reported by the execute stage
    typedef enum logic [1:0] {
        BR_NONE     = 2'b00,
        BR_UNCOND   = 2'b01,
        BR_COND     = 2'b10,
        BR_INDIRECT = 2'b11
    } btype_e;

    // predicted kind handed back to fetch
    // 2'b11 is never produced
    typedef enum logic [1:0] {
        PK_NOT_TAKEN  = 2'b00,
        PK_UNCOND     = 2'b01,
        PK_COND_TAKEN = 2'b10
    } pkind_e;

endpackage

//--- bp_patterns.txt
// fetch_valid fetch_pc upd_valid upd_pc upd_tpc upd_btype upd_taken upd_dir_fail upd_addr_fail
// one cycle per line, hex; btype 0 none, 1 uncond, 2 cond, 3 indirect
1 00001000 0 00000000 00000000 0 0 0 0
1 00001004 0 00000000 00000000 0 0 0 0
// unconditional, taken with wrong target, allocates
0 00000000 1 00001000 00002000 1 1 0 1
1 00001000 0 00000000 00000000 0 0 0 0
// indirect taken with no fail flag, no allocation
0 00000000 1 00001010 00003000 3 1 0 0
1 00001010 0 00000000 00000000 0 0 0 0
0 00000000 1 00001010 00003000 3 1 0 1
1 00001010 0 00000000 00000000 0 0 0 0
// same index as 0x1000, other tag
1 00005000 0 00000000 00000000 0 0 0 0
// conditional at 0x1024, bit 2 set
1 00001024 0 00000000 00000000 0 0 0 0
1 00001024 1 00001024 00004000 2 1 1 0
1 00001024 0 00000000 00000000 0 0 0 0
0 00000000 1 00001024 00004000 2 1 0 0
0 00000000 1 00001024 00004000 2 1 0 0
0 00000000 1 00001024 00004000 2 0 1 0
1 00001024 0 00000000 00000000 0 0 0 0
0 00000000 1 00001024 00004000 2 0 0 0
1 00001024 0 00000000 00000000 0 0 0 0
0 00000000 1 00001024 00004000 2 0 0 0
0 00000000 1 00001024 00004000 2 0 0 0
0 00000000 1 00001024 00004000 2 1 0 0
1 00001024 0 00000000 00000000 0 0 0 0
1 00001024 1 00001024 00004000 2 1 0 0
1 00001024 0 00000000 00000000 0 0 0 0
// counter trains with no entry behind it
0 00000000 1 00002040 00005000 2 1 0 0
0 00000000 1 00002040 00005000 2 1 0 0
1 00002040 0 00000000 00000000 0 0 0 0
// back-to-back fetches
1 00001000 0 00000000 00000000 0 0 0 0
1 00001010 0 00000000 00000000 0 0 0 0
1 00005000 0 00000000 00000000 0 0 0 0
1 00001024 0 00000000 00000000 0 0 0 0
0 00000000 0 00000000 00000000 0 0 0 0
// no branch type, counts a mispredict only
0 00000000 1 00002048 00006000 0 1 1 1
1 00002048 0 00000000 00000000 0 0 0 0

//--- bp_pred_pkg.sv
package bp_pred_pkg;

    import bp_isa_pkg::*;

    // one branch target table entry, full tag so no aliasing
    typedef struct packed {
        logic    valid;
        pc_tag_t tag;
        btype_e  btype;
        addr_t   target;
    } btb_entry_t;

    localparam btb_entry_t BTB_ENTRY_INIT = '{
        valid:  1'b0,
        tag:    '0,
        btype:  BR_NONE,
        target: '0
    };

    // 2-bit saturating direction counter
    // msb set means predict taken
    typedef logic [1:0] ctr_t;

    // weak not taken
    localparam ctr_t CTR_INIT = 2'b01;

    // saturation limits
    localparam ctr_t CTR_MIN = 2'b00;
    localparam ctr_t CTR_MAX = 2'b11;

endpackage

//--- bp_predict_select.sv
`timescale 1ns/1ps

module bp_predict_select
    import bp_isa_pkg::*;
#(
    parameter int INDEX_WIDTH = 6
) (
    input  logic        clk,
    input  logic        rstn,
    bp_lookup_if.select lk,
    input  logic        mispredict,
    output logic        pred_valid,
    output addr_t       pred_pc,
    output pkind_e      pred_taken,
    output logic [31:0] stat_lookups,
    output logic [31:0] stat_mispredicts
);

    logic hit;
    logic ctr_taken;

    // full tag compare, index bits included
    assign hit       = lk.entry.valid && (lk.entry.tag == lk.pc_tag);
    assign ctr_taken = lk.ctr[1];

    always_comb begin
        pred_taken = PK_NOT_TAKEN;
        if (hit) begin
            case (lk.entry.btype)
                BR_UNCOND,
                BR_INDIRECT: pred_taken = PK_UNCOND;
                BR_COND: begin
                    if (ctr_taken) begin
                        pred_taken = PK_COND_TAKEN;
                    end
                end
                default: pred_taken = PK_NOT_TAKEN;
            endcase
        end
    end

    assign pred_valid = lk.valid;
    assign pred_pc    = (pred_taken != PK_NOT_TAKEN) ? lk.entry.target : lk.fallthrough;

    // lookups counted as they leave the pipeline
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            stat_lookups <= '0;
        end else if (lk.valid) begin
            stat_lookups <= stat_lookups + 32'd1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            stat_mispredicts <= '0;
        end else if (mispredict) begin
            stat_mispredicts <= stat_mispredicts + 32'd1;
        end
    end

    // index width is fixed upstream, tag compare covers it
    initial begin
        if (INDEX_WIDTH < 1 || INDEX_WIDTH > 29) begin
            $error("INDEX_WIDTH out of range");
        end
    end

endmodule

//--- bp_resolve_stage.sv
`timescale 1ns/1ps

module bp_resolve_stage
    import bp_isa_pkg::*, bp_pred_pkg::*;
#(
    parameter int INDEX_WIDTH = 6
) (
    input  logic          upd_valid,
    input  addr_t         upd_pc,
    input  addr_t         upd_tpc,
    input  btype_e        upd_btype,
    input  logic          upd_taken,
    input  logic          upd_dir_fail,
    input  logic          upd_addr_fail,
    bp_table_wr_if.writer ent_wr,
    bp_table_wr_if.writer ctr_wr
);

    logic [INDEX_WIDTH-1:0] upd_index;
    logic                   any_fail;
    btb_entry_t             new_entry;
    ctr_t                   ctr_cur;
    ctr_t                   ctr_next;

    assign upd_index = upd_pc[INDEX_WIDTH+2:3];
    assign any_fail  = upd_dir_fail | upd_addr_fail;

    // allocate only on a taken branch that was mispredicted
    always_comb begin
        new_entry        = BTB_ENTRY_INIT;
        new_entry.valid  = 1'b1;
        new_entry.tag    = upd_pc[31:3];
        new_entry.btype  = upd_btype;
        new_entry.target = upd_tpc;
    end

    assign ent_wr.we    = upd_valid & upd_taken & any_fail & (upd_btype != BR_NONE);
    assign ent_wr.waddr = upd_index;
    assign ent_wr.raddr = upd_index;
    assign ent_wr.wdata = new_entry;

    // read-modify-write of the direction counter
    assign ctr_wr.raddr = upd_index;
    assign ctr_cur      = ctr_wr.rdata;

    always_comb begin
        ctr_next = ctr_cur;
        if (upd_taken) begin
            if (ctr_cur != CTR_MAX) begin
                ctr_next = ctr_cur + 2'd1;
            end
        end else begin
            if (ctr_cur != CTR_MIN) begin
                ctr_next = ctr_cur - 2'd1;
            end
        end
    end

    // every resolved conditional trains, hit or miss
    assign ctr_wr.we    = upd_valid & (upd_btype == BR_COND);
    assign ctr_wr.waddr = upd_index;
    assign ctr_wr.wdata = ctr_next;

endmodule

//--- bp_tb.sv
`timescale 1ns/1ps

module bp_tb
    import bp_isa_pkg::*;
();

    localparam int INDEX_WIDTH  = 6;
    localparam int DEPTH        = 1 << INDEX_WIDTH;
    localparam int FIELDS       = 9;
    localparam int MAX_PATTERNS = 64;

    logic        clk;
    logic        rstn;
    logic        fetch_valid;
    addr_t       fetch_pc;
    logic        upd_valid;
    addr_t       upd_pc;
    addr_t       upd_tpc;
    btype_e      upd_btype;
    logic        upd_taken;
    logic        upd_dir_fail;
    logic        upd_addr_fail;
    logic        pred_valid;
    addr_t       pred_pc;
    pkind_e      pred_taken;
    logic [31:0] stat_lookups;
    logic [31:0] stat_mispredicts;

    logic [31:0] pat_mem [FIELDS*MAX_PATTERNS];

    // reference model state
    logic        m_valid  [DEPTH];
    logic [28:0] m_tag    [DEPTH];
    logic [1:0]  m_btype  [DEPTH];
    logic [31:0] m_target [DEPTH];
    logic [1:0]  m_ctr    [DEPTH];
    int          model_lookups;
    int          model_mispredicts;
    logic        exp_valid;
    logic [31:0] exp_pc;
    logic [1:0]  exp_kind;
    int          num_patterns;
    int          cycle_count;
    bit          running;

    bp_top uut (
        .clk              (clk),
        .rstn             (rstn),
        .fetch_valid      (fetch_valid),
        .fetch_pc         (fetch_pc),
        .upd_valid        (upd_valid),
        .upd_pc           (upd_pc),
        .upd_tpc          (upd_tpc),
        .upd_btype        (upd_btype),
        .upd_taken        (upd_taken),
        .upd_dir_fail     (upd_dir_fail),
        .upd_addr_fail    (upd_addr_fail),
        .pred_valid       (pred_valid),
        .pred_pc          (pred_pc),
        .pred_taken       (pred_taken),
        .stat_lookups     (stat_lookups),
        .stat_mispredicts (stat_mispredicts)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (running) begin
            cycle_count = cycle_count + 1;
            if (cycle_count >= num_patterns + 20) begin
                $display("timeout: run did not end within %0d cycles", num_patterns + 20);
                $display("TESTS FAILED");
                $fatal(1, "timeout");
            end
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic model_predict(input logic [31:0] pc);
        int   idx;
        logic hit;
        idx      = pc[INDEX_WIDTH+2:3];
        hit      = m_valid[idx] && (m_tag[idx] == pc[31:3]);
        exp_kind = 2'b00;
        if (hit && (m_btype[idx] == BR_UNCOND || m_btype[idx] == BR_INDIRECT)) begin
            exp_kind = 2'b01;
        end else if (hit && m_btype[idx] == BR_COND && m_ctr[idx][1]) begin
            exp_kind = 2'b10;
        end
        if (exp_kind != 2'b00) begin
            exp_pc = m_target[idx];
        end else if (pc[2]) begin
            exp_pc = pc + 32'd4;
        end else begin
            exp_pc = pc + 32'd8;
        end
    endtask

    task automatic model_update();
        int idx;
        idx = upd_pc[INDEX_WIDTH+2:3];
        if (upd_valid) begin
            if (upd_dir_fail || upd_addr_fail) begin
                model_mispredicts++;
            end
            if (upd_taken && (upd_dir_fail || upd_addr_fail) && upd_btype != BR_NONE) begin
                m_valid[idx]  = 1'b1;
                m_tag[idx]    = upd_pc[31:3];
                m_btype[idx]  = upd_btype;
                m_target[idx] = upd_tpc;
            end
            // saturating at 0 and 3
            if (upd_btype == BR_COND) begin
                if (upd_taken && m_ctr[idx] != 2'b11) begin
                    m_ctr[idx] = m_ctr[idx] + 2'd1;
                end else if (!upd_taken && m_ctr[idx] != 2'b00) begin
                    m_ctr[idx] = m_ctr[idx] - 2'd1;
                end
            end
        end
    endtask

    task automatic apply_pattern(input int i);
        int base;
        base          = i * FIELDS;
        fetch_valid   = pat_mem[base][0];
        fetch_pc      = pat_mem[base+1];
        upd_valid     = pat_mem[base+2][0];
        upd_pc        = pat_mem[base+3];
        upd_tpc       = pat_mem[base+4];
        upd_btype     = btype_e'(pat_mem[base+5][1:0]);
        upd_taken     = pat_mem[base+6][0];
        upd_dir_fail  = pat_mem[base+7][0];
        upd_addr_fail = pat_mem[base+8][0];
        // predict before the same-cycle update lands
        exp_valid = fetch_valid;
        if (fetch_valid) begin
            model_predict(fetch_pc);
            model_lookups++;
        end
        model_update();
    endtask

    task automatic check_prediction(input int i);
        check_value(pred_valid, exp_valid, $sformatf("pred_valid after pattern %0d", i));
        if (exp_valid) begin
            check_value(pred_pc, exp_pc, $sformatf("pred_pc of pattern %0d", i));
            check_value(pred_taken, exp_kind, $sformatf("pred_taken of pattern %0d", i));
        end
    endtask

    initial begin
        clk               = 1'b0;
        rstn              = 1'b0;
        fetch_valid       = 1'b0;
        fetch_pc          = '0;
        upd_valid         = 1'b0;
        upd_pc            = '0;
        upd_tpc           = '0;
        upd_btype         = BR_NONE;
        upd_taken         = 1'b0;
        upd_dir_fail      = 1'b0;
        upd_addr_fail     = 1'b0;
        running           = 1'b0;
        cycle_count       = 0;
        model_lookups     = 0;
        model_mispredicts = 0;
        exp_valid         = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            m_valid[i] = 1'b0;
            // weak not taken
            m_ctr[i]   = 2'b01;
        end
        $readmemh("bp_patterns.txt", pat_mem);
        num_patterns = 0;
        while (num_patterns < MAX_PATTERNS && !$isunknown(pat_mem[num_patterns*FIELDS])) begin
            num_patterns++;
        end
        if (num_patterns == 0) begin
            $display("no patterns could be loaded from bp_patterns.txt");
            $display("TESTS FAILED");
            $fatal(1, "empty pattern file");
        end
        repeat (8) @(posedge clk);
        #1;
        rstn    = 1'b1;
        running = 1'b1;
        for (int i = 0; i < num_patterns; i++) begin
            @(posedge clk);
            #1;
            check_prediction(i - 1);
            apply_pattern(i);
        end
        @(posedge clk);
        #1;
        check_prediction(num_patterns - 1);
        fetch_valid = 1'b0;
        upd_valid   = 1'b0;
        exp_valid   = 1'b0;
        // one more edge so the last lookup reaches the counter
        @(posedge clk);
        #1;
        check_prediction(num_patterns);
        check_value(stat_lookups, model_lookups, "stat_lookups");
        check_value(stat_mispredicts, model_mispredicts, "stat_mispredicts");
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- bp_top.f
bp_isa_pkg.sv
bp_pred_pkg.sv
bp_if.sv
bp_fetch_stage.sv
bp_resolve_stage.sv
pred_table.sv
bp_predict_select.sv
bp_top.sv
bp_assertions.sv
bp_tb.sv

//--- bp_top.sv
`timescale 1ns/1ps

module bp_top #(
    parameter int INDEX_WIDTH = 6
) (
    input  logic                clk,
    input  logic                rstn,
    // fetch side
    input  logic                fetch_valid,
    input  bp_isa_pkg::addr_t   fetch_pc,
    // resolve side from execute
    input  logic                upd_valid,
    input  bp_isa_pkg::addr_t   upd_pc,
    input  bp_isa_pkg::addr_t   upd_tpc,
    input  bp_isa_pkg::btype_e  upd_btype,
    input  logic                upd_taken,
    input  logic                upd_dir_fail,
    input  logic                upd_addr_fail,
    // prediction and statistics
    output logic                pred_valid,
    output bp_isa_pkg::addr_t   pred_pc,
    output bp_isa_pkg::pkind_e  pred_taken,
    output logic [31:0]         stat_lookups,
    output logic [31:0]         stat_mispredicts
);

    logic [INDEX_WIDTH-1:0] rd_index;
    logic                   mispredict;

    bp_lookup_if lk ();

    bp_table_wr_if #(
        .data_t      (bp_pred_pkg::btb_entry_t),
        .INDEX_WIDTH (INDEX_WIDTH)
    ) ent_wr ();

    bp_table_wr_if #(
        .data_t      (bp_pred_pkg::ctr_t),
        .INDEX_WIDTH (INDEX_WIDTH)
    ) ctr_wr ();

    // any reported miss counts, taken or not
    assign mispredict = upd_valid & (upd_dir_fail | upd_addr_fail);

    bp_fetch_stage #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_fetch_stage (
        .clk         (clk),
        .rstn        (rstn),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .lk          (lk.fetch),
        .rd_index    (rd_index)
    );

    bp_resolve_stage #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_resolve_stage (
        .upd_valid     (upd_valid),
        .upd_pc        (upd_pc),
        .upd_tpc       (upd_tpc),
        .upd_btype     (upd_btype),
        .upd_taken     (upd_taken),
        .upd_dir_fail  (upd_dir_fail),
        .upd_addr_fail (upd_addr_fail),
        .ent_wr        (ent_wr.writer),
        .ctr_wr        (ctr_wr.writer)
    );

    pred_table #(
        .payload_t   (bp_pred_pkg::btb_entry_t),
        .INIT        (bp_pred_pkg::BTB_ENTRY_INIT),
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_entry_table (
        .clk      (clk),
        .rstn     (rstn),
        .rd_index (rd_index),
        .rd_data  (lk.entry),
        .wr       (ent_wr.tbl)
    );

    pred_table #(
        .payload_t   (bp_pred_pkg::ctr_t),
        .INIT        (bp_pred_pkg::CTR_INIT),
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_ctr_table (
        .clk      (clk),
        .rstn     (rstn),
        .rd_index (rd_index),
        .rd_data  (lk.ctr),
        .wr       (ctr_wr.tbl)
    );

    bp_predict_select #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_predict_select (
        .clk              (clk),
        .rstn             (rstn),
        .lk               (lk.select),
        .mispredict       (mispredict),
        .pred_valid       (pred_valid),
        .pred_pc          (pred_pc),
        .pred_taken       (pred_taken),
        .stat_lookups     (stat_lookups),
        .stat_mispredicts (stat_mispredicts)
    );

endmodule

//--- pred_table.sv
`timescale 1ns/1ps

module pred_table #(
    parameter type      payload_t   = logic,
    parameter payload_t INIT        = '0,
    parameter int       INDEX_WIDTH = 6
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [INDEX_WIDTH-1:0] rd_index,
    output payload_t               rd_data,
    bp_table_wr_if.tbl             wr
);

    localparam int DEPTH = 1 << INDEX_WIDTH;

    payload_t mem [DEPTH];

    // flops, so every slot has a known start value
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= INIT;
            end
        end else if (wr.we) begin
            mem[wr.waddr] <= wr.wdata;
        end
    end

    // lookup port, old contents when a write lands on the same edge
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_data <= INIT;
        end else begin
            rd_data <= mem[rd_index];
        end
    end

    // update side reads current contents
    assign wr.rdata = mem[wr.raddr];

endmodule
